// ==== dummy_consts.svh ====
/*
  Widths, default seeds, LFSR feedback taps and gap masks for the injector.
  All three LFSRs share one feedback mask. Seeds must be nonzero.
*/
`ifndef DUMMY_CONSTS_SVH
`define DUMMY_CONSTS_SVH

// Instruction and operand width
`define XLEN 32

// Default seeds, also loaded when an LFSR would lock up at zero
`define LFSR0_SEED 32'h2A6E_51C3
`define LFSR1_SEED 32'h9D0B_7F24
`define LFSR2_SEED 32'h4C38_E695

// Right-shifting Galois form of x^32 + x^22 + x^2 + x + 1
`define LFSR_TAPS 32'h8020_0003

`define FREQ_W 4
`define CNT_W 32
`define GAP_W 7

// Gap masks for the five frequency ranges
`define FREQ_MASK_4  7'd3
`define FREQ_MASK_8  7'd7
`define FREQ_MASK_16 7'd15
`define FREQ_MASK_32 7'd31
`define FREQ_MASK_64 7'd63

`endif

// ==== dummy_pkg.sv ====
/*
  Types shared by the dummy-instruction injector.
  The opcode kind is taken directly from two LFSR0 bits.
*/
`include "dummy_consts.svh"

package dummy_pkg;

  // Injector states
  typedef enum logic [0:0] {
    ST_PASS   = 1'b0,
    ST_INSERT = 1'b1
  } fsm_state_e;

  // Kind of dummy instruction, encoded as lfsr0[1:0]
  typedef enum logic [1:0] {
    DOP_ADD  = 2'd0,
    DOP_AND  = 2'd1,
    DOP_MUL  = 2'd2,
    DOP_BLTU = 2'd3
  } dummy_op_e;

  typedef logic [`XLEN-1:0] instr_t;

  typedef logic [4:0] reg_addr_t;

endpackage

// ==== lfsr_if.sv ====
/*
  LFSR values and the advance strobe shared between the injector blocks.
  lockup_seen is high for one cycle after any LFSR was reseeded to its default.
*/
`timescale 1ns/1ns
`include "dummy_consts.svh"

interface lfsr_if;
  logic [`XLEN-1:0] lfsr0;
  logic [`XLEN-1:0] lfsr1;
  logic [`XLEN-1:0] lfsr2;
  logic             advance;
  logic             lockup_seen;

  modport bank (output lfsr0, lfsr1, lfsr2, lockup_seen, input advance);
  modport gap  (input lfsr0, advance);
  modport enc  (input lfsr0, lfsr1, lfsr2);
  modport fsm  (output advance);
endinterface

// ==== dummy_lfsr_bank.sv ====
/*
  Three 32-bit Galois LFSRs that step together on each advance pulse.
  A seed write wins over advance; seed_sel_i of 3 selects no LFSR.
  Any value that would be zero is replaced by that LFSR's default seed.
*/
`timescale 1ns/1ns
`include "dummy_consts.svh"

module dummy_lfsr_bank
  import dummy_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       seed_we_i,
  input  logic [1:0] seed_sel_i,
  input  instr_t     seed_i,
  lfsr_if.bank       lfsr
);

  localparam int NUM_LFSR = 3;

  logic [`XLEN-1:0]    lfsr_q [NUM_LFSR];
  logic [`XLEN-1:0]    lfsr_d [NUM_LFSR];
  logic [NUM_LFSR-1:0] reseed;
  logic                lockup_q;

  function automatic logic [`XLEN-1:0] default_seed(input int idx);
    case (idx)
      0:       return `LFSR0_SEED;
      1:       return `LFSR1_SEED;
      default: return `LFSR2_SEED;
    endcase
  endfunction

  function automatic logic [`XLEN-1:0] galois_step(input logic [`XLEN-1:0] val);
    logic [`XLEN-1:0] shifted;
    shifted = val >> 1;
    return val[0] ? (shifted ^ `LFSR_TAPS) : shifted;
  endfunction

  always_comb begin
    for (int i = 0; i < NUM_LFSR; i++) begin
      if (seed_we_i && (seed_sel_i == 2'(i))) begin
        lfsr_d[i] = seed_i;
      end else if (lfsr.advance) begin
        lfsr_d[i] = galois_step(lfsr_q[i]);
      end else begin
        lfsr_d[i] = lfsr_q[i];
      end
      // Zero is the one state a Galois LFSR never leaves
      reseed[i] = (lfsr_d[i] == '0);
      if (reseed[i]) begin
        lfsr_d[i] = default_seed(i);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int i = 0; i < NUM_LFSR; i++) begin
        lfsr_q[i] <= default_seed(i);
      end
      lockup_q <= 1'b0;
    end else begin
      for (int i = 0; i < NUM_LFSR; i++) begin
        lfsr_q[i] <= lfsr_d[i];
      end
      lockup_q <= |reseed;
    end
  end

  assign lfsr.lfsr0       = lfsr_q[0];
  assign lfsr.lfsr1       = lfsr_q[1];
  assign lfsr.lfsr2       = lfsr_q[2];
  assign lfsr.lockup_seen = lockup_q;

endmodule

// ==== dummy_gap_counter.sv ====
/*
  Counts real words accepted since the last dummy and requests a dummy at the target.
  The target is 1 + (lfsr0 & mask), taken at reset and when a dummy leaves.
  The count is held at zero while dummy_en_i is low.
*/
`timescale 1ns/1ns
`include "dummy_consts.svh"

module dummy_gap_counter (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               dummy_en_i,
  input  logic [`FREQ_W-1:0] freq_i,
  input  logic               real_accept_i,
  lfsr_if.gap                lfsr,
  output logic               dummy_req_o
);

  localparam logic [`XLEN-1:0] SEED0 = `LFSR0_SEED;

  logic [`GAP_W-1:0] mask;
  logic [`GAP_W-1:0] cnt_q;
  logic [`GAP_W-1:0] target_q;

  // The highest set bit of the setting picks the range
  always_comb begin
    casez (freq_i)
      4'b0000: mask = `FREQ_MASK_4;
      4'b0001: mask = `FREQ_MASK_8;
      4'b001?: mask = `FREQ_MASK_16;
      4'b01??: mask = `FREQ_MASK_32;
      default: mask = `FREQ_MASK_64;
    endcase
  end

  // Sampled before the LFSRs step, so it uses the value that chose the last dummy
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      target_q <= (SEED0[`GAP_W-1:0] & mask) + 1'b1;
    end else if (lfsr.advance) begin
      target_q <= (lfsr.lfsr0[`GAP_W-1:0] & mask) + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (!dummy_en_i) begin
      cnt_q <= '0;
    end else if (lfsr.advance) begin
      // A word may enter in the same cycle the dummy leaves
      cnt_q <= real_accept_i ? `GAP_W'(1) : '0;
    end else if (real_accept_i && (cnt_q != target_q)) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign dummy_req_o = dummy_en_i && (cnt_q == target_q);

endmodule

// ==== dummy_instr_encoder.sv ====
/*
  Builds the dummy word from the current LFSR values.
  ADD, AND and MUL write x0; BLTU branches by 4 to the next instruction.
*/
`timescale 1ns/1ns
`include "dummy_consts.svh"

module dummy_instr_encoder
  import dummy_pkg::*;
(
  lfsr_if.enc       lfsr,
  output instr_t    dummy_instr_o,
  output dummy_op_e dummy_op_o
);

  localparam logic [6:0]  OPC_OP     = 7'b0110011;
  localparam logic [6:0]  OPC_BRANCH = 7'b1100011;
  localparam logic [2:0]  F3_ADD     = 3'b000;
  localparam logic [2:0]  F3_AND     = 3'b111;
  localparam logic [2:0]  F3_MUL     = 3'b000;
  localparam logic [2:0]  F3_BLTU    = 3'b110;
  localparam logic [6:0]  F7_BASE    = 7'b0000000;
  localparam logic [6:0]  F7_MULDIV  = 7'b0000001;
  localparam reg_addr_t   REG_X0     = 5'd0;
  localparam logic [12:0] BR_OFFSET  = 13'd4;

  reg_addr_t rs1;
  reg_addr_t rs2;

  assign dummy_op_o = dummy_op_e'(lfsr.lfsr0[1:0]);
  assign rs1        = lfsr.lfsr1[4:0];
  assign rs2        = lfsr.lfsr2[4:0];

  always_comb begin
    unique case (dummy_op_o)
      DOP_ADD: dummy_instr_o = {F7_BASE, rs2, rs1, F3_ADD, REG_X0, OPC_OP};
      DOP_AND: dummy_instr_o = {F7_BASE, rs2, rs1, F3_AND, REG_X0, OPC_OP};
      DOP_MUL: dummy_instr_o = {F7_MULDIV, rs2, rs1, F3_MUL, REG_X0, OPC_OP};
      // B-type; the offset bits land where rd sits in the R-type forms
      default: begin
        dummy_instr_o = {BR_OFFSET[12], BR_OFFSET[10:5], rs2, rs1, F3_BLTU,
                         BR_OFFSET[4:1], BR_OFFSET[11], OPC_BRANCH};
      end
    endcase
  end

endmodule

// ==== dummy_insert_fsm.sv ====
/*
  Passes fetched words to decode through a one-entry output register.
  While a dummy is pending, fetch is held off until the dummy is loaded.
  The register holds its word for as long as decode is not ready.
*/
`timescale 1ns/1ns
`include "dummy_consts.svh"

module dummy_insert_fsm
  import dummy_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   instr_valid_i,
  input  instr_t instr_i,
  input  logic   id_ready_i,
  input  logic   dummy_req_i,
  input  instr_t dummy_instr_i,
  lfsr_if.fsm    lfsr,
  output logic   in_ready_o,
  output logic   out_valid_o,
  output instr_t out_instr_o,
  output logic   out_dummy_o,
  output logic   real_accept_o,
  output logic   dummy_done_o
);

  fsm_state_e state_q;
  fsm_state_e state_d;
  logic       out_valid_q;
  logic       out_dummy_q;
  instr_t     out_instr_q;
  logic       reg_free;
  logic       deliver;
  logic       req_pend;
  logic       accept;
  logic       load_dummy;

  assign reg_free = !out_valid_q || id_ready_i;
  assign deliver  = out_valid_q && id_ready_i;

  // A request is already served once its dummy sits in the register
  assign req_pend = dummy_req_i && !(out_valid_q && out_dummy_q);

  assign in_ready_o = (state_q == ST_PASS) && !req_pend && reg_free;
  assign accept     = instr_valid_i && in_ready_o;
  assign load_dummy = (state_q == ST_INSERT) && dummy_req_i && reg_free;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_PASS: begin
        if (req_pend) begin
          state_d = ST_INSERT;
        end
      end
      ST_INSERT: begin
        // Dropping the enable cancels a dummy that was not yet loaded
        if (load_dummy || !dummy_req_i) begin
          state_d = ST_PASS;
        end
      end
      default: state_d = ST_PASS;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q     <= ST_PASS;
      out_valid_q <= 1'b0;
      out_dummy_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept || load_dummy) begin
        out_valid_q <= 1'b1;
        out_dummy_q <= load_dummy;
      end else if (deliver) begin
        out_valid_q <= 1'b0;
        out_dummy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      out_instr_q <= instr_i;
    end else if (load_dummy) begin
      out_instr_q <= dummy_instr_i;
    end
  end

  assign out_valid_o   = out_valid_q;
  assign out_instr_o   = out_instr_q;
  assign out_dummy_o   = out_dummy_q;
  assign real_accept_o = accept;
  assign dummy_done_o  = deliver && out_dummy_q;
  assign lfsr.advance  = dummy_done_o;

endmodule

// ==== perf_counters.sv ====
/*
  mcycle counts every cycle after reset and wraps to zero.
  minstret counts real deliveries only; dummies never retire.
*/
`timescale 1ns/1ns
`include "dummy_consts.svh"

module perf_counters (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              real_done_i,
  output logic [`CNT_W-1:0] mcycle_o,
  output logic [`CNT_W-1:0] minstret_o
);

  logic [`CNT_W-1:0] mcycle_q;
  logic [`CNT_W-1:0] minstret_q;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      mcycle_q   <= '0;
      minstret_q <= '0;
    end else begin
      mcycle_q <= mcycle_q + 1'b1;
      if (real_done_i) begin
        minstret_q <= minstret_q + 1'b1;
      end
    end
  end

  assign mcycle_o   = mcycle_q;
  assign minstret_o = minstret_q;

endmodule

// ==== dummy_inject_top.sv ====
/*
  Dummy-instruction injector between fetch and decode, with plain strobes only.
  op_a_o and op_b_o show lfsr1 and lfsr2 while a dummy is on the output.
  A seed write while a dummy is stalled changes these operand ports.
*/
`timescale 1ns/1ns
`include "dummy_consts.svh"

module dummy_inject_top
  import dummy_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               instr_valid_i,
  input  instr_t             instr_i,
  input  logic               id_ready_i,
  input  logic               dummy_en_i,
  input  logic [`FREQ_W-1:0] dummy_freq_i,
  input  logic               seed_we_i,
  input  logic [1:0]         seed_sel_i,
  input  instr_t             seed_i,
  output logic               in_ready_o,
  output logic               out_valid_o,
  output instr_t             out_instr_o,
  output logic               out_dummy_o,
  output logic [`XLEN-1:0]   op_a_o,
  output logic [`XLEN-1:0]   op_b_o,
  output logic [`CNT_W-1:0]  mcycle_o,
  output logic [`CNT_W-1:0]  minstret_o
);

  logic      dummy_req;
  logic      real_accept;
  logic      dummy_done;
  logic      real_done;
  instr_t    dummy_instr;

  lfsr_if u_lfsr_if ();

  dummy_lfsr_bank u_lfsr_bank (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .seed_we_i  (seed_we_i),
    .seed_sel_i (seed_sel_i),
    .seed_i     (seed_i),
    .lfsr       (u_lfsr_if.bank)
  );

  dummy_gap_counter u_gap_counter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .dummy_en_i    (dummy_en_i),
    .freq_i        (dummy_freq_i),
    .real_accept_i (real_accept),
    .lfsr          (u_lfsr_if.gap),
    .dummy_req_o   (dummy_req)
  );

  dummy_instr_encoder u_instr_encoder (
    .lfsr          (u_lfsr_if.enc),
    .dummy_instr_o (dummy_instr),
    .dummy_op_o    ()
  );

  dummy_insert_fsm u_insert_fsm (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .id_ready_i    (id_ready_i),
    .dummy_req_i   (dummy_req),
    .dummy_instr_i (dummy_instr),
    .lfsr          (u_lfsr_if.fsm),
    .in_ready_o    (in_ready_o),
    .out_valid_o   (out_valid_o),
    .out_instr_o   (out_instr_o),
    .out_dummy_o   (out_dummy_o),
    .real_accept_o (real_accept),
    .dummy_done_o  (dummy_done)
  );

  // Any delivery that is not a dummy retires one instruction
  assign real_done = out_valid_o && id_ready_i && !dummy_done;

  perf_counters u_perf_counters (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .real_done_i (real_done),
    .mcycle_o    (mcycle_o),
    .minstret_o  (minstret_o)
  );

  assign op_a_o = out_dummy_o ? u_lfsr_if.lfsr1 : '0;
  assign op_b_o = out_dummy_o ? u_lfsr_if.lfsr2 : '0;

endmodule

// ==== dummy_inject_chk.sv ====
/*
  Concurrent checks on the injector output and the LFSR bank, bound to the top level.
  All checks are off while reset is held.
*/
`timescale 1ns/1ns
`include "dummy_consts.svh"

module dummy_inject_chk
  import dummy_pkg::*;
(
  input logic             clk_i,
  input logic             rst_ni,
  input logic             en_i,
  input logic             ready_i,
  input logic             valid_i,
  input logic             dummy_i,
  input instr_t           instr_i,
  input logic [`XLEN-1:0] lfsr0_i,
  input logic [`XLEN-1:0] lfsr1_i,
  input logic [`XLEN-1:0] lfsr2_i
);

  // Branch dummies carry offset bits in the rd field
  a_rd_x0: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (valid_i && dummy_i && instr_i[6:0] != 7'b1100011) |-> instr_i[11:7] == 5'd0)
    else $error("dummy word writes a register other than x0");

  a_no_dummy_off: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !en_i |-> !(valid_i && dummy_i))
    else $error("dummy word on the output while insertion is disabled");

  a_stall_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (valid_i && !ready_i) |=> (valid_i && $stable(instr_i) && $stable(dummy_i)))
    else $error("output changed while decode was stalled");

  a_lfsr_nonzero: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (lfsr0_i != '0) && (lfsr1_i != '0) && (lfsr2_i != '0))
    else $error("an LFSR holds zero");

endmodule

bind dummy_inject_top dummy_inject_chk u_dummy_inject_chk (
  .clk_i   (clk_i),
  .rst_ni  (rst_ni),
  .en_i    (dummy_en_i),
  .ready_i (id_ready_i),
  .valid_i (out_valid_o),
  .dummy_i (out_dummy_o),
  .instr_i (out_instr_o),
  .lfsr0_i (u_lfsr_if.lfsr0),
  .lfsr1_i (u_lfsr_if.lfsr1),
  .lfsr2_i (u_lfsr_if.lfsr2)
);

// ==== tb_dummy_inject.sv ====
/*
  Testbench for the dummy-instruction injector. Inputs change on the falling edge.
  The model predicts every output word, including dummies and their operands.
  Frequency and enable change only while reset is held.
*/
`timescale 1ns/1ns
`include "dummy_consts.svh"

module tb_dummy_inject import dummy_pkg::*; ();

  localparam logic [`FREQ_W-1:0] FREQ_SET [5] = '{4'b0000, 4'b0001, 4'b0011, 4'b0110, 4'b1010};

  logic               clk_i;
  logic               rst_ni;
  logic               instr_valid_i;
  instr_t             instr_i;
  logic               id_ready_i;
  logic               dummy_en_i;
  logic [`FREQ_W-1:0] dummy_freq_i;
  logic               seed_we_i;
  logic [1:0]         seed_sel_i;
  instr_t             seed_i;
  logic               in_ready_o;
  logic               out_valid_o;
  instr_t             out_instr_o;
  logic               out_dummy_o;
  logic [`XLEN-1:0]   op_a_o;
  logic [`XLEN-1:0]   op_b_o;
  logic [`CNT_W-1:0]  mcycle_o;
  logic [`CNT_W-1:0]  minstret_o;

  int                seed = 14798;
  instr_t            in_words[$];
  instr_t            exp_word_q[$];
  logic              exp_dummy_q[$];
  instr_t            exp_opa_q[$];
  instr_t            exp_opb_q[$];
  logic [`XLEN-1:0]  m_lfsr [3];
  logic [`XLEN-1:0]  m_count;
  logic [`XLEN-1:0]  m_target;
  logic [`CNT_W-1:0] cyc_cnt;
  logic [`CNT_W-1:0] real_cnt;
  logic              exp_dummy;

  dummy_inject_top u_dummy_inject_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic logic [`XLEN-1:0] seed_default(input int idx);
    if (idx == 0) return `LFSR0_SEED;
    if (idx == 1) return `LFSR1_SEED;
    return `LFSR2_SEED;
  endfunction

  // Galois step; a zero result falls back to the default seed
  function automatic logic [`XLEN-1:0] lfsr_next(input int idx, input logic [`XLEN-1:0] v);
    logic [`XLEN-1:0] nxt;
    nxt = v[0] ? ((v >> 1) ^ `LFSR_TAPS) : (v >> 1);
    return (nxt == '0) ? seed_default(idx) : nxt;
  endfunction

  function automatic logic [`XLEN-1:0] gap_mask(input logic [`FREQ_W-1:0] f);
    if (f[3]) return 32'd63;
    if (f[2]) return 32'd31;
    if (f[1]) return 32'd15;
    if (f[0]) return 32'd7;
    return 32'd3;
  endfunction

  // Reference encoding of a dummy from the three LFSR values
  function automatic instr_t dummy_word(input logic [`XLEN-1:0] l0, l1, l2);
    reg_addr_t rs1;
    reg_addr_t rs2;
    rs1 = l1[4:0];
    rs2 = l2[4:0];
    case (dummy_op_e'(l0[1:0]))
      DOP_ADD: return {7'b0000000, rs2, rs1, 3'b000, 5'd0, 7'b0110011};
      DOP_AND: return {7'b0000000, rs2, rs1, 3'b111, 5'd0, 7'b0110011};
      DOP_MUL: return {7'b0000001, rs2, rs1, 3'b000, 5'd0, 7'b0110011};
      default: return {7'b0000000, rs2, rs1, 3'b110, 5'b00100, 7'b1100011};
    endcase
  endfunction

  task automatic halt_failed();
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic abort_run(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    halt_failed();
  endtask

  task automatic word_equal(input instr_t act, input instr_t exp, input string what);
    if (act !== exp) begin
      $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, act, exp);
      halt_failed();
    end
  endtask

  task automatic flag_equal(input logic act, input logic exp, input string what);
    if (act !== exp) begin
      $display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, act, exp);
      halt_failed();
    end
  endtask

  task automatic count_equal(input logic [`CNT_W-1:0] act, input logic [`CNT_W-1:0] exp,
                             input string what);
    if (act !== exp) begin
      $display("[FAIL] %0t ns: %s is %0d, expected %0d", $time, what, act, exp);
      halt_failed();
    end
  endtask

  task automatic push_expected(input instr_t w, input logic d, input instr_t a, input instr_t b);
    exp_word_q.push_back(w);
    exp_dummy_q.push_back(d);
    exp_opa_q.push_back(a);
    exp_opb_q.push_back(b);
  endtask

  task automatic apply_reset(input logic en, input logic [`FREQ_W-1:0] freq);
    @(negedge clk_i);
    rst_ni        = 1'b0;
    dummy_en_i    = en;
    dummy_freq_i  = freq;
    instr_valid_i = 1'b0;
    id_ready_i    = 1'b1;
    seed_we_i     = 1'b0;
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    for (int j = 0; j < 3; j++) begin
      m_lfsr[j] = seed_default(j);
    end
    m_count  = '0;
    m_target = (`LFSR0_SEED & gap_mask(freq)) + 1;
  endtask

  // A zero seed raises the lockup flag for the cycle after the write
  task automatic write_seed(input logic [1:0] sel, input instr_t val);
    @(negedge clk_i);
    seed_we_i   = 1'b1;
    seed_sel_i  = sel;
    seed_i      = val;
    m_lfsr[sel] = (val == '0) ? seed_default(sel) : val;
    @(negedge clk_i);
    flag_equal(u_dummy_inject_top.u_lfsr_if.lockup_seen, (val == '0), "lockup flag");
    seed_we_i = 1'b0;
  endtask

  // Random real words, with a dummy after each completed gap
  task automatic build_expected(input int n);
    instr_t w;
    for (int i = 0; i < n; i++) begin
      w = $random(seed);
      in_words.push_back(w);
      push_expected(w, 1'b0, '0, '0);
      if (dummy_en_i) begin
        m_count = m_count + 1;
        if (m_count == m_target) begin
          push_expected(dummy_word(m_lfsr[0], m_lfsr[1], m_lfsr[2]), 1'b1, m_lfsr[1], m_lfsr[2]);
          m_count  = '0;
          m_target = (m_lfsr[0] & gap_mask(dummy_freq_i)) + 1;
          for (int j = 0; j < 3; j++) begin
            m_lfsr[j] = lfsr_next(j, m_lfsr[j]);
          end
        end
      end
    end
  endtask

  task automatic run_stream(input bit stall);
    int guard;
    guard = 0;
    forever begin
      @(negedge clk_i);
      if (exp_word_q.size() == 0) break;
      if (guard > 5000) abort_run("timeout while waiting for the output stream");
      guard++;
      instr_valid_i = (in_words.size() > 0) && ({$random(seed)} % 4 != 0);
      instr_i       = (in_words.size() > 0) ? in_words[0] : '0;
      id_ready_i    = stall ? ({$random(seed)} % 3 != 0) : 1'b1;
      @(posedge clk_i);
      if (instr_valid_i && in_ready_o) begin
        void'(in_words.pop_front());
      end
    end
    instr_valid_i = 1'b0;
    id_ready_i    = 1'b1;
  endtask

  task automatic check_counters();
    count_equal(minstret_o, real_cnt, "minstret");
    count_equal(mcycle_o, cyc_cnt, "mcycle");
  endtask

  // Compare each delivered word with the head of the expected queues
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      cyc_cnt  = '0;
      real_cnt = '0;
    end else begin
      cyc_cnt = cyc_cnt + 1;
      if (out_valid_o && id_ready_i) begin
        if (exp_word_q.size() == 0) abort_run("output word delivered with none expected");
        word_equal(out_instr_o, exp_word_q.pop_front(), "output word");
        word_equal(op_a_o, exp_opa_q.pop_front(), "operand a");
        word_equal(op_b_o, exp_opb_q.pop_front(), "operand b");
        exp_dummy = exp_dummy_q.pop_front();
        flag_equal(out_dummy_o, exp_dummy, "dummy flag");
        if (!exp_dummy) real_cnt = real_cnt + 1;
      end
    end
  end

  initial begin
    rst_ni        = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    id_ready_i    = 1'b1;
    dummy_en_i    = 1'b0;
    dummy_freq_i  = '0;
    seed_we_i     = 1'b0;
    seed_sel_i    = '0;
    seed_i        = '0;
    // Plain pass-through
    apply_reset(1'b0, 4'b0000);
    build_expected(40);
    run_stream(1'b0);
    check_counters();
    for (int k = 0; k < 5; k++) begin
      apply_reset(1'b1, FREQ_SET[k]);
      build_expected(150);
      run_stream(1'b0);
      check_counters();
    end
    // Back-pressure from decode
    apply_reset(1'b1, 4'b0010);
    build_expected(200);
    run_stream(1'b1);
    check_counters();
    // New seeds, then a zero seed that falls back to the default
    apply_reset(1'b1, 4'b0001);
    write_seed(2'd0, 32'h1357_9BDF);
    write_seed(2'd1, 32'h0F1E_2D3C);
    write_seed(2'd2, 32'h8642_ACE0);
    build_expected(60);
    run_stream(1'b1);
    check_counters();
    write_seed(2'd1, '0);
    build_expected(60);
    run_stream(1'b0);
    check_counters();
    if (exp_word_q.size() == 0 && in_words.size() == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      abort_run("words were left in the stimulus or expected queues");
    end
  end

endmodule

// ==== filelist.f ====
+incdir+.
dummy_pkg.sv
lfsr_if.sv
dummy_lfsr_bank.sv
dummy_gap_counter.sv
dummy_instr_encoder.sv
dummy_insert_fsm.sv
perf_counters.sv
dummy_inject_top.sv
dummy_inject_chk.sv
tb_dummy_inject.sv

// ==== Makefile ====
# Verilator build and run of the dummy-instruction injector testbench
SIM := obj_dir/Vtb_dummy_inject

all: run

$(SIM): filelist.f $(wildcard *.sv *.svh)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_dummy_inject -f filelist.f

run: $(SIM)
	./$(SIM) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "SIMULATION FAILED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
